//--- Makefile
# Verilator build and run for the VGA frame reader testbench.

VERILATOR ?= verilator
TOP       ?= tb_vga_frame_reader
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= Everything OK

SRCS := $(filter-out +%,$(shell cat $(FILELIST)))
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- all.f
vga_timing_pkg.sv
vga_bus_pkg.sv
vga_timing.sv
vga_fetch.sv
pixel_buffer.sv
vga_frame_reader.sv
vga_properties.sv
tb_vga_frame_reader.sv

//--- pixel_buffer.sv
`timescale 1ns/10ps

module pixel_buffer (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               wr_en,
    input  logic                               wr_slot,
    input  logic [vga_bus_pkg::data_w-1:0]     wr_data,
    input  logic [vga_timing_pkg::coord_w-1:0] row,
    input  logic [vga_timing_pkg::coord_w-1:0] col,
    input  logic                               disp_active,
    input  logic                               hsync,
    input  logic                               vsync,
    output logic [2:0]                         vga_r,
    output logic [2:0]                         vga_g,
    output logic [1:0]                         vga_b,
    output logic                               vga_hs,
    output logic                               vga_vs
);
    import vga_timing_pkg::*;
    import vga_bus_pkg::*;

    logic [data_w-1:0] slot_q [2];
    logic [31:0]       pix_idx;
    logic [data_w-1:0] word;
    logic [7:0]        pix_byte;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            slot_q[wr_slot] <= wr_data;
        end
    end

    ////////////////////////////////////////////////////////////
    // byte select for the display position
    ////////////////////////////////////////////////////////////

    assign pix_idx  = 32'(row >> 1) * 32'(fb_width) + 32'(col >> 2);
    assign word     = slot_q[pix_idx[1]];
    assign pix_byte = pix_idx[0] ? word[7:0] : word[data_w-1 -: 8];  // even pixel is high byte.

    // colour and sync leave on the same edge.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vga_r  <= '0;
            vga_g  <= '0;
            vga_b  <= '0;
            vga_hs <= 1'b1;
            vga_vs <= 1'b1;
        end else begin
            if (disp_active) begin
                vga_r <= pix_byte[7:5];
                vga_g <= pix_byte[4:2];
                vga_b <= pix_byte[1:0];
            end else begin
                vga_r <= '0;  // blank.
                vga_g <= '0;
                vga_b <= '0;
            end
            vga_hs <= hsync;
            vga_vs <= vsync;
        end
    end

endmodule

//--- tb_vga_frame_reader.sv
`timescale 1ns/10ps

module tb_vga_frame_reader;
    import vga_timing_pkg::*;
    import vga_bus_pkg::*;

    localparam int clk_period    = 40;
    localparam int reset_cycles  = 10;
    localparam int frame_cycles  = h_total * v_total;
    localparam int run_cycles    = 2 * frame_cycles;
    localparam int line_words    = fb_width / 2;
    localparam int fb_words      = line_words * fb_height;
    localparam int max_err_lines = 8;

    // test numbers, also the index into the counters.
    localparam int t_reset = 0;
    localparam int t_addr  = 1;
    localparam int t_color = 2;
    localparam int t_blank = 3;
    localparam int t_sync  = 4;
    localparam int t_bus   = 5;
    localparam int n_tests = 6;

    logic              clk;
    logic              rst_n;
    logic              bus_req;
    logic [addr_w-1:0] bus_addr;
    logic              bus_ack;
    logic              bus_wait;
    logic [data_w-1:0] bus_data;
    logic [2:0]        vga_r;
    logic [2:0]        vga_g;
    logic [1:0]        vga_b;
    logic              vga_hs;
    logic              vga_vs;

    logic [data_w-1:0] mem [fb_words];
    string             test_name [n_tests];
    int                checks [n_tests];
    int                errors [n_tests];
    int                accepted;  // granted requests so far.

    vga_frame_reader UUT (
        .clk      (clk),
        .rst_n    (rst_n),
        .bus_req  (bus_req),
        .bus_addr (bus_addr),
        .bus_ack  (bus_ack),
        .bus_wait (bus_wait),
        .bus_data (bus_data),
        .vga_r    (vga_r),
        .vga_g    (vga_g),
        .vga_b    (vga_b),
        .vga_hs   (vga_hs),
        .vga_vs   (vga_vs)
    );

    bind vga_fetch vga_properties u_props (
        .clk      (clk),
        .rst_n    (rst_n),
        .bus_req  (bus_req),
        .bus_ack  (bus_ack),
        .bus_addr (bus_addr),
        .wr_en    (wr_en)
    );

    task automatic log_mismatch(input int t, input int exp, input int act);
        errors[t]++;
        if (errors[t] <= max_err_lines) begin
            $display("ERR %s expected %0h actual %0h at %0t", test_name[t], exp, act, $time);
        end
    endtask

    task automatic report_test(input int t);
        $display("test %s: %0d checks, %0d errors", test_name[t], checks[t], errors[t]);
    endtask

    // blank colour and both syncs inactive.
    task automatic check_idle_outputs();
        checks[t_reset] += 2;
        if ({vga_r, vga_g, vga_b} != 8'd0) begin
            log_mismatch(t_reset, 0, int'({vga_r, vga_g, vga_b}));
        end
        if ({vga_hs, vga_vs} != 2'b11) begin
            log_mismatch(t_reset, 3, int'({vga_hs, vga_vs}));
        end
    endtask

    task automatic check_no_request();
        checks[t_reset]++;
        if (bus_req !== 1'b0) begin
            log_mismatch(t_reset, 0, int'(bus_req));
        end
    endtask

    function automatic int pixel_index(input int r, input int c);
        return (r / 2) * fb_width + c / 4;
    endfunction

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // memory bus model
    ////////////////////////////////////////////////////////////

    initial begin
        int delay;
        int waits;
        int idx;
        int k;
        int want;
        @(posedge rst_n);
        forever begin
            @(posedge clk);
            #2;
            if (bus_req) begin
                delay = int'($urandom_range(2, 0));
                repeat (delay) begin
                    @(posedge clk);
                    #2;
                end
                bus_ack = 1'b1;
                @(posedge clk);
                #2;
                bus_ack = 1'b0;  // granted on that edge.
                k = accepted % (v_active * line_words);
                want = ((k / line_words) / 2) * line_words + k % line_words;
                idx = int'(bus_addr - fb_base);
                checks[t_addr]++;
                if (idx != want) begin
                    log_mismatch(t_addr, int'(fb_base) + want, int'(bus_addr));
                end
                accepted++;
                waits = int'($urandom_range(1, 0));
                bus_wait = (waits != 0);
                repeat (1 + waits) begin
                    @(posedge clk);
                    #2;
                end
                bus_wait = 1'b0;
                bus_data = (idx >= 0 && idx < fb_words) ? mem[idx] : '0;
                repeat (2) begin  // read_data, then finish.
                    @(posedge clk);
                    #2;
                end
                checks[t_bus]++;
                if (bus_req) begin
                    errors[t_bus]++;
                    $display("bus protocol: bus_req still high in the cycle after read_data");
                end
            end
        end
    end

    initial begin
        #((3 * frame_cycles + reset_cycles) * clk_period);
        $display("timeout: the run did not end within three frames of clocks");
        $display("Something failed");
        $finish;
    end

    ////////////////////////////////////////////////////////////
    // reference model and checks
    ////////////////////////////////////////////////////////////

    initial begin
        int          r;
        int          c;
        int          pix;
        int          want;
        int          hs_low;
        int          vs_lines;
        int          asserts;
        int          total_chk;
        int          total_err;
        logic [15:0] word;
        logic        want_hs;
        logic        want_vs;
        logic        line_seen;
        logic        frame_seen;

        rst_n    = 1'b0;
        bus_ack  = 1'b0;
        bus_wait = 1'b0;
        bus_data = '0;
        accepted = 0;
        test_name[t_reset] = "reset";
        test_name[t_addr]  = "address";
        test_name[t_color] = "colour";
        test_name[t_blank] = "blanking";
        test_name[t_sync]  = "sync";
        test_name[t_bus]   = "bus";
        for (int t = 0; t < n_tests; t++) begin
            checks[t] = 0;
            errors[t] = 0;
        end
        void'($urandom(32'h88630e1d));
        for (int i = 0; i < fb_words; i++) begin
            mem[i] = data_w'($urandom);
        end

        repeat (reset_cycles) begin
            @(posedge clk);
            #1;
            check_idle_outputs();
            check_no_request();
        end
        #1;
        rst_n = 1'b1;
        #1;
        check_no_request();

        // display sits lead clocks before the first pixel.
        r = v_total - 1;
        c = h_total - lead;
        hs_low     = 0;
        vs_lines   = 0;
        line_seen  = 1'b0;
        frame_seen = 1'b0;
        for (int i = 0; i < run_cycles; i++) begin
            @(posedge clk);
            #1;
            if (i == 0) begin
                check_idle_outputs();
                report_test(t_reset);
            end
            if (c < h_active && r < v_active) begin
                pix  = pixel_index(r, c);
                word = mem[pix / 2];
                want = (pix % 2 == 0) ? int'(word[15:8]) : int'(word[7:0]);
                checks[t_color]++;
                if ({vga_r, vga_g, vga_b} != 8'(want)) begin
                    log_mismatch(t_color, want, int'({vga_r, vga_g, vga_b}));
                end
            end else begin
                checks[t_blank]++;
                if ({vga_r, vga_g, vga_b} != 8'd0) begin
                    log_mismatch(t_blank, 0, int'({vga_r, vga_g, vga_b}));
                end
            end
            want_hs = (c >= h_active + h_front && c < h_active + h_front + h_sync) ? 1'b0 : 1'b1;
            want_vs = (r >= v_active + v_front && r < v_active + v_front + v_sync) ? 1'b0 : 1'b1;
            checks[t_sync] += 2;
            if (vga_hs != want_hs) begin
                log_mismatch(t_sync, int'(want_hs), int'(vga_hs));
            end
            if (vga_vs != want_vs) begin
                log_mismatch(t_sync, int'(want_vs), int'(vga_vs));
            end
            // pulse lengths, over whole lines and frames only.
            if (c == 0) begin
                line_seen = 1'b1;
                hs_low = 0;
                if (r == 0) begin
                    frame_seen = 1'b1;
                    vs_lines = 0;
                end
                if (!vga_vs) vs_lines++;
            end
            if (!vga_hs) hs_low++;
            if (line_seen && c == h_total - 1) begin
                checks[t_sync]++;
                if (hs_low != h_sync) log_mismatch(t_sync, h_sync, hs_low);
            end
            if (frame_seen && c == h_total - 1 && r == v_total - 1) begin
                checks[t_sync]++;
                if (vs_lines != v_sync) log_mismatch(t_sync, v_sync, vs_lines);
            end
            c++;
            if (c == h_total) begin
                c = 0;
                r = (r == v_total - 1) ? 0 : r + 1;
            end
        end

        checks[t_addr]++;
        if (accepted != 2 * v_active * line_words) begin
            log_mismatch(t_addr, 2 * v_active * line_words, accepted);
        end
        for (int t = 1; t < n_tests; t++) begin
            report_test(t);
        end
        asserts   = UUT.u_fetch.u_props.fail_count;
        total_chk = 0;
        total_err = asserts;
        for (int t = 0; t < n_tests; t++) begin
            total_chk += checks[t];
            total_err += errors[t];
        end
        $display("%0d checks, %0d errors, %0d assertion failures", total_chk, total_err, asserts);
        if (total_err == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

//--- vga_bus_pkg.sv
package vga_bus_pkg;

    localparam int addr_w = 32;
    localparam int data_w = 16;  // two pixels per word.

    // word address of framebuffer word 0.
    localparam logic [addr_w-1:0] fb_base = 32'h00001050;

    ////////////////////////////////////////////////////////////
    // fetch state machine
    ////////////////////////////////////////////////////////////

    typedef enum logic [2:0] {
        fetch_idle,
        fetch_present_addr,
        fetch_wait,
        fetch_read_data,
        fetch_finish
    } fetch_state_t;

endpackage

//--- vga_fetch.sv
`timescale 1ns/10ps

module vga_fetch (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic [vga_timing_pkg::coord_w-1:0] lead_row,
    input  logic [vga_timing_pkg::coord_w-1:0] lead_col,
    input  logic                               lead_active,
    input  logic                               bus_ack,
    input  logic                               bus_wait,
    input  logic [vga_bus_pkg::data_w-1:0]     bus_data,
    output logic                               bus_req,
    output logic [vga_bus_pkg::addr_w-1:0]     bus_addr,
    output logic                               wr_en,
    output logic                               wr_slot,
    output logic [vga_bus_pkg::data_w-1:0]     wr_data
);
    import vga_timing_pkg::*;
    import vga_bus_pkg::*;

    logic [addr_w-1:0] pix_idx;
    logic [addr_w-1:0] lead_word;
    logic [addr_w-1:0] lead_addr;
    logic [addr_w-1:0] addr_q;     // address of the word in flight.
    logic [addr_w-1:0] last_addr;
    logic              slot_q;
    logic              need_fetch;
    fetch_state_t      state;
    fetch_state_t      state_nxt;

    ////////////////////////////////////////////////////////////
    // lead word address
    ////////////////////////////////////////////////////////////

    assign pix_idx   = addr_w'(lead_row >> 1) * addr_w'(fb_width) + addr_w'(lead_col >> 2);
    assign lead_word = pix_idx >> 1;
    assign lead_addr = fb_base + lead_word;

    assign need_fetch = lead_active && (lead_addr != last_addr);

    ////////////////////////////////////////////////////////////
    // state machine
    ////////////////////////////////////////////////////////////

    always_comb begin
        state_nxt = state;
        unique case (state)
            fetch_idle:         if (need_fetch && bus_ack) state_nxt = fetch_present_addr;
            fetch_present_addr: state_nxt = fetch_wait;
            fetch_wait:         if (!bus_wait) state_nxt = fetch_read_data;
            fetch_read_data:    state_nxt = fetch_finish;
            fetch_finish:       state_nxt = fetch_idle;
            default:            state_nxt = fetch_idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= fetch_idle;
            last_addr <= '1;  // no word matches, so the first is always read.
        end else begin
            state <= state_nxt;
            if (state == fetch_present_addr) begin
                last_addr <= addr_q;
            end
        end
    end

    // captured on the grant so the address holds while the lead moves on.
    always_ff @(posedge clk) begin
        if (state == fetch_idle && need_fetch && bus_ack) begin
            addr_q <= lead_addr;
            slot_q <= lead_word[0];
        end
    end

    // request is held from the grant through read_data.
    always_comb begin
        unique case (state)
            fetch_idle:         bus_req = need_fetch;
            fetch_present_addr: bus_req = 1'b1;
            fetch_wait:         bus_req = 1'b1;
            fetch_read_data:    bus_req = 1'b1;
            default:            bus_req = 1'b0;
        endcase
    end

    assign bus_addr = (state == fetch_idle) ? lead_addr : addr_q;

    assign wr_en   = (state == fetch_read_data);
    assign wr_slot = slot_q;   // word parity.
    assign wr_data = bus_data;

endmodule

//--- vga_frame_reader.sv
`timescale 1ns/10ps

module vga_frame_reader (
    input  logic                           clk,
    input  logic                           rst_n,
    output logic                           bus_req,
    output logic [vga_bus_pkg::addr_w-1:0] bus_addr,
    input  logic                           bus_ack,
    input  logic                           bus_wait,
    input  logic [vga_bus_pkg::data_w-1:0] bus_data,
    output logic [2:0]                     vga_r,
    output logic [2:0]                     vga_g,
    output logic [1:0]                     vga_b,
    output logic                           vga_hs,
    output logic                           vga_vs
);
    import vga_timing_pkg::*;
    import vga_bus_pkg::*;

    logic [coord_w-1:0] row;
    logic [coord_w-1:0] col;
    logic [coord_w-1:0] lead_row;
    logic [coord_w-1:0] lead_col;
    logic               disp_active;
    logic               lead_active;
    logic               hsync;
    logic               vsync;
    logic               wr_en;
    logic               wr_slot;
    logic [data_w-1:0]  wr_data;

    vga_timing u_timing (
        .clk         (clk),
        .rst_n       (rst_n),
        .row         (row),
        .col         (col),
        .lead_row    (lead_row),
        .lead_col    (lead_col),
        .disp_active (disp_active),
        .lead_active (lead_active),
        .hsync       (hsync),
        .vsync       (vsync)
    );

    vga_fetch u_fetch (
        .clk         (clk),
        .rst_n       (rst_n),
        .lead_row    (lead_row),
        .lead_col    (lead_col),
        .lead_active (lead_active),
        .bus_ack     (bus_ack),
        .bus_wait    (bus_wait),
        .bus_data    (bus_data),
        .bus_req     (bus_req),
        .bus_addr    (bus_addr),
        .wr_en       (wr_en),
        .wr_slot     (wr_slot),
        .wr_data     (wr_data)
    );

    pixel_buffer u_buffer (
        .clk         (clk),
        .rst_n       (rst_n),
        .wr_en       (wr_en),
        .wr_slot     (wr_slot),
        .wr_data     (wr_data),
        .row         (row),
        .col         (col),
        .disp_active (disp_active),
        .hsync       (hsync),
        .vsync       (vsync),
        .vga_r       (vga_r),
        .vga_g       (vga_g),
        .vga_b       (vga_b),
        .vga_hs      (vga_hs),
        .vga_vs      (vga_vs)
    );

endmodule

//--- vga_properties.sv
`timescale 1ns/10ps

module vga_properties (
    input logic                           clk,
    input logic                           rst_n,
    input logic                           bus_req,
    input logic                           bus_ack,
    input logic [vga_bus_pkg::addr_w-1:0] bus_addr,
    input logic                           wr_en
);

    int   fail_count = 0;  // read back at the end of the run.
    logic in_xfer;         // between a grant and its buffer write.

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            in_xfer <= 1'b0;
        end else if (wr_en) begin
            in_xfer <= 1'b0;
        end else if (bus_req && bus_ack) begin
            in_xfer <= 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////
    // request level
    ////////////////////////////////////////////////////////////

    // once granted, the request stays up through the data phase.
    req_held: assert property (@(posedge clk) disable iff (!rst_n)
        in_xfer |-> bus_req)
        else begin
            fail_count++;
            $error("bus_req dropped between the grant and read_data");
        end

    addr_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (bus_req && $past(bus_req)) |-> (bus_addr == $past(bus_addr)))
        else begin
            fail_count++;
            $error("bus_addr changed while bus_req was high");
        end

    // one buffer write per fetched word.
    single_write: assert property (@(posedge clk) disable iff (!rst_n)
        wr_en |=> !wr_en)
        else begin
            fail_count++;
            $error("wr_en high for two cycles in a row");
        end

endmodule

//--- vga_timing.sv
`timescale 1ns/10ps

module vga_timing (
    input  logic                               clk,
    input  logic                               rst_n,
    output logic [vga_timing_pkg::coord_w-1:0] row,
    output logic [vga_timing_pkg::coord_w-1:0] col,
    output logic [vga_timing_pkg::coord_w-1:0] lead_row,
    output logic [vga_timing_pkg::coord_w-1:0] lead_col,
    output logic                               disp_active,
    output logic                               lead_active,
    output logic                               hsync,
    output logic                               vsync
);
    import vga_timing_pkg::*;

    logic [coord_w-1:0] row_nxt;
    logic [coord_w-1:0] col_nxt;
    logic [coord_w-1:0] lead_row_nxt;
    logic [coord_w-1:0] lead_col_nxt;

    // one pixel clock further along the raster, {row, col}.
    function automatic logic [2*coord_w-1:0] step(input logic [coord_w-1:0] r,
                                                  input logic [coord_w-1:0] c);
        logic [coord_w-1:0] r_n;
        logic [coord_w-1:0] c_n;
        r_n = r;
        c_n = c + 1'b1;
        if (c == coord_w'(h_total - 1)) begin
            c_n = '0;
            r_n = (r == coord_w'(v_total - 1)) ? '0 : r + 1'b1;
        end
        return {r_n, c_n};
    endfunction

    function automatic logic is_active(input logic [coord_w-1:0] r,
                                       input logic [coord_w-1:0] c);
        return (c < h_active) && (r < v_active);
    endfunction

    assign {row_nxt, col_nxt}           = step(row, col);
    assign {lead_row_nxt, lead_col_nxt} = step(lead_row, lead_col);

    ////////////////////////////////////////////////////////////
    // counters and flags, all registered
    ////////////////////////////////////////////////////////////

    // display starts lead clocks before the end of the frame, so the
    // lead pair sits at the first pixel and fetches word 0 in time.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            row         <= coord_w'(v_total - 1);
            col         <= coord_w'(h_total - lead);
            lead_row    <= '0;
            lead_col    <= '0;
            disp_active <= 1'b0;
            lead_active <= 1'b0;  // no request while in reset.
            hsync       <= 1'b1;
            vsync       <= 1'b1;
        end else begin
            row         <= row_nxt;
            col         <= col_nxt;
            lead_row    <= lead_row_nxt;
            lead_col    <= lead_col_nxt;
            disp_active <= is_active(row_nxt, col_nxt);
            lead_active <= is_active(lead_row_nxt, lead_col_nxt);
            // sync pulses are active low.
            hsync <= !((col_nxt >= h_active + h_front) &&
                       (col_nxt <  h_active + h_front + h_sync));
            vsync <= !((row_nxt >= v_active + v_front) &&
                       (row_nxt <  v_active + v_front + v_sync));
        end
    end

endmodule

//--- vga_timing_pkg.sv
package vga_timing_pkg;

    ////////////////////////////////////////////////////////////
    // horizontal timing, in pixel clocks
    ////////////////////////////////////////////////////////////

    localparam int h_active = 640;
    localparam int h_front  = 16;
    localparam int h_sync   = 96;
    localparam int h_back   = 48;
    localparam int h_total  = h_active + h_front + h_sync + h_back;  // 800.

    ////////////////////////////////////////////////////////////
    // vertical timing, in lines
    ////////////////////////////////////////////////////////////

    localparam int v_active = 480;
    localparam int v_front  = 10;
    localparam int v_sync   = 2;
    localparam int v_back   = 33;
    localparam int v_total  = v_active + v_front + v_sync + v_back;  // 525.

    ////////////////////////////////////////////////////////////
    // framebuffer geometry
    ////////////////////////////////////////////////////////////

    // each stored pixel covers 4 columns and 2 lines.
    localparam int fb_width  = h_active / 4;  // 160.
    localparam int fb_height = v_active / 2;  // 240.

    localparam int coord_w = 11;

    // fetch position runs one word of screen columns ahead.
    localparam int lead = 2 * (h_active / fb_width);  // 8.

endpackage
